//--- build.f
source/abacus_map_pkg.sv
source/abacus_isa_pkg.sv
source/instruction_classifier.sv
source/cache_event_decoder.sv
source/event_counter_bank.sv
source/wishbone_register_file.sv
source/abacus_top.sv
test/abacus_asserts.sv
test/abacus_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module abacus_tb -f build.f \
	--Mdir obj_dir -o abacus_sim

./obj_dir/abacus_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
exit 1

//--- source/abacus_isa_pkg.sv
package abacus_isa_pkg;

	// RV32 major opcodes that the profiler looks at
	localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
	localparam logic [6:0] OPC_STORE  = 7'b010_0011;
	localparam logic [6:0] OPC_OP     = 7'b011_0011;
	localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
	localparam logic [6:0] OPC_JAL    = 7'b110_1111;
	localparam logic [6:0] OPC_JALR   = 7'b110_0111;
	localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;
	localparam logic [6:0] OPC_AMO    = 7'b010_1111;

	// R-type field layout, opcode in the low bits
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_instr_t;

	// Instruction classes, also the counter order in the 0x100 block
	localparam int CLS_LOAD   = 0;
	localparam int CLS_STORE  = 1;
	localparam int CLS_ADD    = 2;
	localparam int CLS_SUB    = 3;
	localparam int CLS_LOGIC  = 4;
	localparam int CLS_SHIFT  = 5;
	localparam int CLS_CMP    = 6;
	localparam int CLS_BRANCH = 7;
	localparam int CLS_JUMP   = 8;
	localparam int CLS_SYSTEM = 9;
	localparam int CLS_ATOMIC = 10;

	localparam int NUM_INSTR_CLASSES = 11;

	// Cache statistics, also the counter order in the 0x200 block
	localparam int IC_REQ  = 0;
	localparam int IC_HIT  = 1;
	localparam int IC_MISS = 2;
	localparam int IC_FILL = 3;
	localparam int DC_REQ  = 4;
	localparam int DC_HIT  = 5;
	localparam int DC_MISS = 6;
	localparam int DC_FILL = 7;

	localparam int NUM_CACHE_EVENTS = 8;

	// Raw levels from the core's caches
	// The I-cache reports a miss, the D-cache a hit
	typedef struct packed {
		logic ic_req;
		logic ic_miss;
		logic ic_fill;
		logic dc_req;
		logic dc_hit;
		logic dc_fill;
	} cache_sig_t;

endpackage

//--- source/abacus_map_pkg.sv
package abacus_map_pkg;

	// Counter width, also the width of the bus data path
	localparam int COUNT_W = 32;

	// Byte address width of the Wishbone port
	localparam int ADDR_W = 32;

	// Counters of a block sit one word apart
	localparam int REG_STRIDE = 4;

	// Enable registers, relative to the base address
	localparam logic [ADDR_W-1:0] INSTR_EN_OFS = 32'h0000_0004;
	localparam logic [ADDR_W-1:0] CACHE_EN_OFS = 32'h0000_0008;

	// Counter blocks, relative to the base address
	// Counter k of a block is at block offset + REG_STRIDE * k
	localparam logic [ADDR_W-1:0] INSTR_BLOCK_OFS = 32'h0000_0100;
	localparam logic [ADDR_W-1:0] CACHE_BLOCK_OFS = 32'h0000_0200;

	// Master to slave, 67 bits
	typedef struct packed {
		logic               cyc;
		logic               stb;
		logic               we;
		logic [ADDR_W-1:0]  adr;
		logic [COUNT_W-1:0] dat;
	} wb_req_t;

	// Slave to master, 33 bits
	// dat is only meaningful while a read is on the bus
	typedef struct packed {
		logic [COUNT_W-1:0] dat;
		logic               ack;
	} wb_rsp_t;

endpackage

//--- source/abacus_top.sv
module abacus_top
#(
	parameter logic [abacus_map_pkg::ADDR_W-1:0] BASE_ADDR = 32'hF003_0000
)
(
	input  logic                       S_AXI_ACLK,
	input  logic                       rst,
	input  abacus_isa_pkg::rv_instr_t  instr_i,
	input  logic                       instr_issued_i,
	input  abacus_isa_pkg::cache_sig_t cache_i,
	input  abacus_map_pkg::wb_req_t    wb_req_i,
	output abacus_map_pkg::wb_rsp_t    wb_rsp_o
);

	localparam int NUM_INSTR = abacus_isa_pkg::NUM_INSTR_CLASSES;
	localparam int NUM_CACHE = abacus_isa_pkg::NUM_CACHE_EVENTS;

	logic [NUM_INSTR-1:0]                              instr_event;
	logic [NUM_CACHE-1:0]                              cache_event;
	logic [NUM_INSTR-1:0][abacus_map_pkg::COUNT_W-1:0] instr_count;
	logic [NUM_CACHE-1:0][abacus_map_pkg::COUNT_W-1:0] cache_count;
	logic                                              instr_en;
	logic                                              cache_en;

	instruction_classifier u_classifier (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.instr_i    (instr_i),
		.issued_i   (instr_issued_i),
		.class_o    (instr_event)
	);

	cache_event_decoder u_cache_decoder (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.cache_i    (cache_i),
		.event_o    (cache_event)
	);

	// One counter per instruction class
	event_counter_bank #(
		.NUM_COUNTERS (NUM_INSTR)
	) u_instr_bank (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.enable_i   (instr_en),
		.event_i    (instr_event),
		.count_o    (instr_count)
	);

	// One counter per cache statistic
	event_counter_bank #(
		.NUM_COUNTERS (NUM_CACHE)
	) u_cache_bank (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.enable_i   (cache_en),
		.event_i    (cache_event),
		.count_o    (cache_count)
	);

	wishbone_register_file #(
		.BASE_ADDR (BASE_ADDR)
	) u_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.rst           (rst),
		.wb_req_i      (wb_req_i),
		.wb_rsp_o      (wb_rsp_o),
		.instr_count_i (instr_count),
		.cache_count_i (cache_count),
		.instr_en_o    (instr_en),
		.cache_en_o    (cache_en)
	);

endmodule

//--- source/cache_event_decoder.sv
module cache_event_decoder
(
	input  logic                                         S_AXI_ACLK,
	input  logic                                         rst,
	input  abacus_isa_pkg::cache_sig_t                   cache_i,
	output logic [abacus_isa_pkg::NUM_CACHE_EVENTS-1:0] event_o
);

	logic [abacus_isa_pkg::NUM_CACHE_EVENTS-1:0] next_event;

	always_comb
	begin
		// I-cache side, hit is derived from the miss level
		next_event[abacus_isa_pkg::IC_REQ]  = cache_i.ic_req;
		next_event[abacus_isa_pkg::IC_HIT]  = cache_i.ic_req & ~cache_i.ic_miss;
		next_event[abacus_isa_pkg::IC_MISS] = cache_i.ic_req & cache_i.ic_miss;
		next_event[abacus_isa_pkg::IC_FILL] = cache_i.ic_fill;

		// D-cache side, miss is derived from the hit level
		next_event[abacus_isa_pkg::DC_REQ]  = cache_i.dc_req;
		next_event[abacus_isa_pkg::DC_HIT]  = cache_i.dc_req & cache_i.dc_hit;
		next_event[abacus_isa_pkg::DC_MISS] = cache_i.dc_req & ~cache_i.dc_hit;
		next_event[abacus_isa_pkg::DC_FILL] = cache_i.dc_fill;
	end

	// Fill events stay high for every cycle a line fill is in progress,
	// so the fill counters measure latency in cycles
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
			event_o <= '0;
		else
			event_o <= next_event;
	end

endmodule

//--- source/event_counter_bank.sv
module event_counter_bank
#(
	parameter int NUM_COUNTERS = 8
)
(
	input  logic                                                      S_AXI_ACLK,
	input  logic                                                      rst,
	input  logic                                                      enable_i,
	input  logic [NUM_COUNTERS-1:0]                                   event_i,
	output logic [NUM_COUNTERS-1:0][abacus_map_pkg::COUNT_W-1:0]      count_o
);

	// Events arrive whatever the enable, the enable only gates the update
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			count_o <= '0;
		end
		else if (enable_i)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
			begin
				// Wraps from all-ones back to zero
				if (event_i[i])
					count_o[i] <= count_o[i] + abacus_map_pkg::COUNT_W'(1);
			end
		end
	end

endmodule

//--- source/instruction_classifier.sv
module instruction_classifier
(
	input  logic                                          S_AXI_ACLK,
	input  logic                                          rst,
	input  abacus_isa_pkg::rv_instr_t                     instr_i,
	input  logic                                          issued_i,
	output logic [abacus_isa_pkg::NUM_INSTR_CLASSES-1:0] class_o
);

	logic [abacus_isa_pkg::NUM_INSTR_CLASSES-1:0] next_class;
	logic                                         is_reg_op;

	// Only register-register ops use funct7 to tell SUB from ADD
	assign is_reg_op = (instr_i.opcode == abacus_isa_pkg::OPC_OP);

	always_comb
	begin
		next_class = '0;
		case (instr_i.opcode)
			abacus_isa_pkg::OPC_LOAD:
				next_class[abacus_isa_pkg::CLS_LOAD] = 1'b1;
			abacus_isa_pkg::OPC_STORE:
				next_class[abacus_isa_pkg::CLS_STORE] = 1'b1;
			abacus_isa_pkg::OPC_OP,
			abacus_isa_pkg::OPC_OP_IMM:
			begin
				case (instr_i.funct3)
					3'b000:
					begin
						if (is_reg_op && instr_i.funct7[5])
							next_class[abacus_isa_pkg::CLS_SUB] = 1'b1;
						else
							next_class[abacus_isa_pkg::CLS_ADD] = 1'b1;
					end
					3'b001,
					3'b101:
						next_class[abacus_isa_pkg::CLS_SHIFT] = 1'b1;
					3'b010,
					3'b011:
						next_class[abacus_isa_pkg::CLS_CMP] = 1'b1;
					// 100, 110 and 111 are XOR, OR and AND
					default:
						next_class[abacus_isa_pkg::CLS_LOGIC] = 1'b1;
				endcase
			end
			abacus_isa_pkg::OPC_BRANCH:
				next_class[abacus_isa_pkg::CLS_BRANCH] = 1'b1;
			abacus_isa_pkg::OPC_JAL,
			abacus_isa_pkg::OPC_JALR:
				next_class[abacus_isa_pkg::CLS_JUMP] = 1'b1;
			abacus_isa_pkg::OPC_SYSTEM:
				next_class[abacus_isa_pkg::CLS_SYSTEM] = 1'b1;
			abacus_isa_pkg::OPC_AMO:
				next_class[abacus_isa_pkg::CLS_ATOMIC] = 1'b1;
			// LUI, AUIPC and anything unknown are not profiled
			default:
				next_class = '0;
		endcase
	end

	// One-hot for one cycle per issued instruction
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
			class_o <= '0;
		else if (issued_i)
			class_o <= next_class;
		else
			class_o <= '0;
	end

endmodule

//--- source/wishbone_register_file.sv
module wishbone_register_file
#(
	parameter logic [abacus_map_pkg::ADDR_W-1:0] BASE_ADDR = 32'hF003_0000
)
(
	input  logic                          S_AXI_ACLK,
	input  logic                          rst,
	input  abacus_map_pkg::wb_req_t       wb_req_i,
	output abacus_map_pkg::wb_rsp_t       wb_rsp_o,
	input  logic [abacus_isa_pkg::NUM_INSTR_CLASSES-1:0][abacus_map_pkg::COUNT_W-1:0]
		instr_count_i,
	input  logic [abacus_isa_pkg::NUM_CACHE_EVENTS-1:0][abacus_map_pkg::COUNT_W-1:0]
		cache_count_i,
	output logic                          instr_en_o,
	output logic                          cache_en_o
);

	localparam int ADDR_W      = abacus_map_pkg::ADDR_W;
	localparam int COUNT_W     = abacus_map_pkg::COUNT_W;
	localparam int STRIDE_LSB  = $clog2(abacus_map_pkg::REG_STRIDE);
	localparam int INSTR_IDX_W = $clog2(abacus_isa_pkg::NUM_INSTR_CLASSES);
	localparam int CACHE_IDX_W = $clog2(abacus_isa_pkg::NUM_CACHE_EVENTS);

	localparam logic [ADDR_W-1:0] INSTR_SPAN =
		ADDR_W'(abacus_map_pkg::REG_STRIDE * abacus_isa_pkg::NUM_INSTR_CLASSES);
	localparam logic [ADDR_W-1:0] CACHE_SPAN =
		ADDR_W'(abacus_map_pkg::REG_STRIDE * abacus_isa_pkg::NUM_CACHE_EVENTS);

	logic [COUNT_W-1:0]     instr_en;
	logic [COUNT_W-1:0]     cache_en;
	logic                   ack_q;
	logic [ADDR_W-1:0]      ofs;
	logic [ADDR_W-1:0]      instr_rel;
	logic [ADDR_W-1:0]      cache_rel;
	logic                   instr_hit;
	logic                   cache_hit;
	logic [INSTR_IDX_W-1:0] instr_idx;
	logic [CACHE_IDX_W-1:0] cache_idx;
	logic [COUNT_W-1:0]     rd_data;
	logic                   req_valid;
	logic                   rd_valid;

	assign req_valid = wb_req_i.cyc & wb_req_i.stb;
	assign rd_valid  = req_valid & ~wb_req_i.we;

	// Offset of the access from the base, then from each counter block
	assign ofs       = wb_req_i.adr - BASE_ADDR;
	assign instr_rel = ofs - abacus_map_pkg::INSTR_BLOCK_OFS;
	assign cache_rel = ofs - abacus_map_pkg::CACHE_BLOCK_OFS;

	// Unaligned addresses inside a block are treated as unmapped
	assign instr_hit = (instr_rel < INSTR_SPAN) && (instr_rel[STRIDE_LSB-1:0] == '0);
	assign cache_hit = (cache_rel < CACHE_SPAN) && (cache_rel[STRIDE_LSB-1:0] == '0);
	assign instr_idx = instr_rel[STRIDE_LSB +: INSTR_IDX_W];
	assign cache_idx = cache_rel[STRIDE_LSB +: CACHE_IDX_W];

	// Single-cycle ack, the enable write lands on the same edge
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			ack_q    <= 1'b0;
			instr_en <= '0;
			cache_en <= '0;
		end
		else
		begin
			ack_q <= req_valid & ~ack_q;
			if (req_valid && wb_req_i.we && !ack_q)
			begin
				if (ofs == abacus_map_pkg::INSTR_EN_OFS)
					instr_en <= wb_req_i.dat;
				else if (ofs == abacus_map_pkg::CACHE_EN_OFS)
					cache_en <= wb_req_i.dat;
			end
		end
	end

	always_comb
	begin
		rd_data = '0;
		if (ofs == abacus_map_pkg::INSTR_EN_OFS)
			rd_data = instr_en;
		else if (ofs == abacus_map_pkg::CACHE_EN_OFS)
			rd_data = cache_en;
		else if (instr_hit)
			rd_data = instr_count_i[instr_idx];
		else if (cache_hit)
			rd_data = cache_count_i[cache_idx];
	end

	assign wb_rsp_o = '{dat: (rd_valid ? rd_data : '0), ack: ack_q};

	// Only bit 0 of each enable register has a function
	assign instr_en_o = instr_en[0];
	assign cache_en_o = cache_en[0];

endmodule

//--- test/abacus_asserts.sv
module abacus_asserts
#(
	parameter logic [abacus_map_pkg::ADDR_W-1:0] BASE_ADDR = 32'hF003_0000
)
(
	input  logic                       S_AXI_ACLK,
	input  logic                       rst,
	input  abacus_isa_pkg::rv_instr_t  instr_i,
	input  logic                       issued_i,
	input  abacus_isa_pkg::cache_sig_t cache_i,
	input  abacus_map_pkg::wb_req_t    wb_req_i,
	input  abacus_map_pkg::wb_rsp_t    wb_rsp_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned        fail_count = 0;
	logic [10:0]        exp_class;
	logic [7:0]         exp_event;
	logic [10:0][31:0]  exp_instr_cnt;
	logic [7:0][31:0]   exp_cache_cnt;
	logic [31:0]        exp_instr_en;
	logic [31:0]        exp_cache_en;
	logic               exp_ack;
	logic [31:0]        exp_rd;
	logic [31:0]        ofs;
	logic [31:0]        rel_instr;
	logic [31:0]        rel_cache;
	logic               req_valid;
	logic               rd_req;

	// Class of an issued word, straight from the decode table
	function automatic logic [10:0] class_of(input abacus_isa_pkg::rv_instr_t w);
		logic [10:0] v;
		logic        alu;
		v = '0;
		alu = (w.opcode == abacus_isa_pkg::OPC_OP) || (w.opcode == abacus_isa_pkg::OPC_OP_IMM);
		if (w.opcode == abacus_isa_pkg::OPC_LOAD)
			v[abacus_isa_pkg::CLS_LOAD] = 1'b1;
		else if (w.opcode == abacus_isa_pkg::OPC_STORE)
			v[abacus_isa_pkg::CLS_STORE] = 1'b1;
		else if (alu && w.funct3 == 3'b000 && w.opcode == abacus_isa_pkg::OPC_OP && w.funct7[5])
			v[abacus_isa_pkg::CLS_SUB] = 1'b1;
		else if (alu && w.funct3 == 3'b000)
			v[abacus_isa_pkg::CLS_ADD] = 1'b1;
		else if (alu && (w.funct3 == 3'b001 || w.funct3 == 3'b101))
			v[abacus_isa_pkg::CLS_SHIFT] = 1'b1;
		else if (alu && (w.funct3 == 3'b010 || w.funct3 == 3'b011))
			v[abacus_isa_pkg::CLS_CMP] = 1'b1;
		else if (alu)
			v[abacus_isa_pkg::CLS_LOGIC] = 1'b1;
		else if (w.opcode == abacus_isa_pkg::OPC_BRANCH)
			v[abacus_isa_pkg::CLS_BRANCH] = 1'b1;
		else if (w.opcode == abacus_isa_pkg::OPC_JAL || w.opcode == abacus_isa_pkg::OPC_JALR)
			v[abacus_isa_pkg::CLS_JUMP] = 1'b1;
		else if (w.opcode == abacus_isa_pkg::OPC_SYSTEM)
			v[abacus_isa_pkg::CLS_SYSTEM] = 1'b1;
		else if (w.opcode == abacus_isa_pkg::OPC_AMO)
			v[abacus_isa_pkg::CLS_ATOMIC] = 1'b1;
		return v;
	endfunction

	assign req_valid = wb_req_i.cyc & wb_req_i.stb;
	assign rd_req    = req_valid & ~wb_req_i.we;
	assign ofs       = wb_req_i.adr - BASE_ADDR;

	// Shadow of the bus slave and both 2-cycle counting paths
	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			exp_ack       <= 1'b0;
			exp_instr_en  <= '0;
			exp_cache_en  <= '0;
			exp_class     <= '0;
			exp_event     <= '0;
			exp_instr_cnt <= '0;
			exp_cache_cnt <= '0;
		end
		else
		begin
			exp_ack <= req_valid & ~exp_ack;
			if (req_valid && wb_req_i.we && !exp_ack && ofs == 32'h4)
				exp_instr_en <= wb_req_i.dat;
			if (req_valid && wb_req_i.we && !exp_ack && ofs == 32'h8)
				exp_cache_en <= wb_req_i.dat;
			exp_class <= issued_i ? class_of(instr_i) : 11'd0;
			exp_event <= {cache_i.dc_fill, cache_i.dc_req & ~cache_i.dc_hit,
				cache_i.dc_req & cache_i.dc_hit, cache_i.dc_req, cache_i.ic_fill,
				cache_i.ic_req & cache_i.ic_miss, cache_i.ic_req & ~cache_i.ic_miss,
				cache_i.ic_req};
			for (int k = 0; k < 11; k++)
				if (exp_instr_en[0] && exp_class[k])
					exp_instr_cnt[k] <= exp_instr_cnt[k] + 32'd1;
			for (int k = 0; k < 8; k++)
				if (exp_cache_en[0] && exp_event[k])
					exp_cache_cnt[k] <= exp_cache_cnt[k] + 32'd1;
		end
	end

	// Expected read value, zero for anything outside the map
	always_comb
	begin
		rel_instr = ofs - 32'h100;
		rel_cache = ofs - 32'h200;
		exp_rd = '0;
		if (ofs == 32'h4)
			exp_rd = exp_instr_en;
		else if (ofs == 32'h8)
			exp_rd = exp_cache_en;
		else if (rel_instr < 32'd44 && rel_instr[1:0] == 2'b00)
			exp_rd = exp_instr_cnt[rel_instr[5:2]];
		else if (rel_cache < 32'd32 && rel_cache[1:0] == 2'b00)
			exp_rd = exp_cache_cnt[rel_cache[4:2]];
	end

	ack_after_request: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		(req_valid && !wb_rsp_i.ack) |=> wb_rsp_i.ack)
	else begin fail_count++; $error("ack did not follow an open request"); end

	ack_one_cycle: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
	else begin fail_count++; $error("ack stayed high for more than one cycle"); end

	ack_only_when_asked: assert property (@(posedge S_AXI_ACLK)
		(rst || !(req_valid && !wb_rsp_i.ack)) |=> !wb_rsp_i.ack)
	else begin fail_count++; $error("ack rose without a request"); end

	read_data_match: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		(rd_req && wb_rsp_i.ack) |-> (wb_rsp_i.dat == exp_rd))
	else begin
		fail_count++;
		$error("** Error %0t: wb_rsp_o.dat = 0x%08h, expected 0x%08h", $time,
			$sampled(wb_rsp_i.dat), $sampled(exp_rd));
	end

	data_zero_idle: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		!rd_req |-> (wb_rsp_i.dat == 32'd0))
	else begin
		fail_count++;
		$error("** Error %0t: wb_rsp_o.dat = 0x%08h, expected 0x00000000", $time,
			$sampled(wb_rsp_i.dat));
	end

endmodule

bind abacus_top abacus_asserts #(.BASE_ADDR(BASE_ADDR)) u_asserts (
	.S_AXI_ACLK (S_AXI_ACLK),
	.rst        (rst),
	.instr_i    (instr_i),
	.issued_i   (instr_issued_i),
	.cache_i    (cache_i),
	.wb_req_i   (wb_req_i),
	.wb_rsp_i   (wb_rsp_o)
);

//--- test/abacus_tb.sv
module abacus_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] BASE = 32'hF003_0000;
	// Rough cycle budget per test, reset first
	localparam int TEST_CYCLES = 16 + 100 + 700 + 400 + 500 + 284;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	// Gaps between and just past the mapped regions, plus far outside
	localparam logic [31:0] UNMAPPED_OFS [8] = '{32'h0, 32'hC, 32'hFC, 32'h12C, 32'h220,
		32'h300, 32'h1000, 32'hFFFF_FFFC};

	logic                       S_AXI_ACLK;
	logic                       rst;
	abacus_isa_pkg::rv_instr_t  instr;
	logic                       instr_issued;
	abacus_isa_pkg::cache_sig_t cache;
	abacus_map_pkg::wb_req_t    wb_req;
	abacus_map_pkg::wb_rsp_t    wb_rsp;
	int                         cycle_count = 0;
	int                         test_num = 1;
	int                         pass_cnt = 0;
	int                         fail_cnt = 0;
	int unsigned                fails_seen = 0;

	abacus_top #(.BASE_ADDR(BASE)) DUT (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.rst            (rst),
		.instr_i        (instr),
		.instr_issued_i (instr_issued),
		.cache_i        (cache),
		.wb_req_i       (wb_req),
		.wb_rsp_o       (wb_rsp)
	);

	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, a test never finished", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic idle(input int n);
		repeat (n) @(posedge S_AXI_ACLK);
	endtask

	// One bus transfer, released at the edge after ack
	task automatic bus_xfer(input logic we, input logic [31:0] ofs, input logic [31:0] dat);
		@(posedge S_AXI_ACLK);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: BASE + ofs, dat: dat};
		do @(negedge S_AXI_ACLK); while (!wb_rsp.ack);
		@(posedge S_AXI_ACLK);
		wb_req <= '0;
	endtask

	// Request held open, so ack pulses every second cycle
	task automatic bus_hold(input logic we, input logic [31:0] ofs, input logic [31:0] dat);
		@(posedge S_AXI_ACLK);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: BASE + ofs, dat: dat};
		idle(9);
		wb_req <= '0;
	endtask

	task automatic read_counters();
		for (int k = 0; k < 11; k++)
			bus_xfer(1'b0, 32'h100 + 32'(4 * k), '0);
		for (int k = 0; k < 8; k++)
			bus_xfer(1'b0, 32'h200 + 32'(4 * k), '0);
	endtask

	// Kinds 0 to 13 cover every class, ADDI, LUI and AUIPC
	function automatic abacus_isa_pkg::rv_instr_t make_instr(input int kind);
		abacus_isa_pkg::rv_instr_t w;
		w = abacus_isa_pkg::rv_instr_t'($urandom);
		case (kind)
			0: w.opcode = abacus_isa_pkg::OPC_LOAD;
			1: w.opcode = abacus_isa_pkg::OPC_STORE;
			2: w = '{funct7: 7'h00, rs2: w.rs2, rs1: w.rs1, funct3: 3'b000, rd: w.rd,
				opcode: abacus_isa_pkg::OPC_OP};
			3: w = '{funct7: 7'h20, rs2: w.rs2, rs1: w.rs1, funct3: 3'b000, rd: w.rd,
				opcode: abacus_isa_pkg::OPC_OP};
			4: w.funct3 = ($urandom_range(1, 0) != 0) ? 3'b100 : 3'b11 + 3'($urandom_range(4, 3));
			5: w.funct3 = ($urandom_range(1, 0) != 0) ? 3'b001 : 3'b101;
			6: w.funct3 = ($urandom_range(1, 0) != 0) ? 3'b010 : 3'b011;
			7: w.opcode = abacus_isa_pkg::OPC_BRANCH;
			8: w.opcode = ($urandom_range(1, 0) != 0) ? abacus_isa_pkg::OPC_JAL
				: abacus_isa_pkg::OPC_JALR;
			9: w.opcode = abacus_isa_pkg::OPC_SYSTEM;
			10: w.opcode = abacus_isa_pkg::OPC_AMO;
			11: w.opcode = 7'b011_0111;
			12: w.opcode = 7'b001_0111;
			default: w.funct3 = 3'b000;
		endcase
		// ALU kinds pick either operand form
		if (kind >= 4 && kind <= 6)
			w.opcode = ($urandom_range(1, 0) != 0) ? abacus_isa_pkg::OPC_OP
				: abacus_isa_pkg::OPC_OP_IMM;
		if (kind == 13)
			w.opcode = abacus_isa_pkg::OPC_OP_IMM;
		return w;
	endfunction

	task automatic issue_random(input int count);
		repeat (count)
		begin
			repeat ($urandom_range(3, 0))
			begin
				@(posedge S_AXI_ACLK);
				instr <= abacus_isa_pkg::rv_instr_t'($urandom);
				instr_issued <= 1'b0;
			end
			@(posedge S_AXI_ACLK);
			instr <= make_instr(int'($urandom_range(13, 0)));
			instr_issued <= 1'b1;
		end
		@(posedge S_AXI_ACLK);
		instr_issued <= 1'b0;
	endtask

	task automatic cache_random(input int cycles);
		repeat (cycles)
		begin
			@(posedge S_AXI_ACLK);
			cache <= abacus_isa_pkg::cache_sig_t'(6'($urandom));
		end
		@(posedge S_AXI_ACLK);
		cache <= '0;
	endtask

	task automatic end_test(input string name);
		int unsigned now_fails;
		idle(3);
		now_fails = DUT.u_asserts.fail_count;
		if (now_fails == fails_seen)
		begin
			$display("Test %0d %s: passed", test_num, name);
			pass_cnt++;
		end
		else
		begin
			$display("Test %0d %s: FAILED with %0d assertion failures", test_num, name,
				now_fails - fails_seen);
			fail_cnt++;
		end
		fails_seen = now_fails;
		test_num++;
	endtask

	initial
	begin
		S_AXI_ACLK = 1'b0;
		rst = 1'b1;
		instr = '0;
		instr_issued = 1'b0;
		cache = '0;
		wb_req = '0;
		void'($urandom(32'h3923ab89));
		idle(16);
		rst <= 1'b0;

		read_counters();
		bus_xfer(1'b0, 32'h4, '0);
		bus_xfer(1'b0, 32'h8, '0);
		for (int i = 0; i < 8; i++)
			bus_xfer(1'b0, UNMAPPED_OFS[i], '0);
		end_test("reset values and unmapped reads");

		bus_xfer(1'b1, 32'h4, 32'h1);
		issue_random(200);
		idle(2);
		read_counters();
		end_test("instruction classes");

		bus_xfer(1'b1, 32'h8, 32'h1);
		cache_random(300);
		idle(2);
		read_counters();
		end_test("cache statistics");

		bus_xfer(1'b1, 32'h4, 32'h0);
		bus_xfer(1'b1, 32'h8, 32'h0);
		fork
			issue_random(40);
			cache_random(60);
		join
		read_counters();
		fork
			issue_random(60);
			cache_random(150);
			begin
				idle(20);
				bus_xfer(1'b1, 32'h4, 32'h1);
				bus_xfer(1'b1, 32'h8, 32'h1);
				idle(40);
				bus_xfer(1'b1, 32'h4, 32'h0);
				bus_xfer(1'b1, 32'h8, 32'h0);
			end
		join
		read_counters();
		end_test("enable gating");

		bus_xfer(1'b1, 32'h4, 32'h5A5A_C3C3);
		bus_xfer(1'b1, 32'h8, 32'hA5A5_3C3C);
		bus_xfer(1'b0, 32'h4, '0);
		bus_xfer(1'b0, 32'h8, '0);
		bus_hold(1'b0, 32'h4, '0);
		bus_hold(1'b1, 32'h8, 32'h0000_0001);
		bus_xfer(1'b0, 32'h8, '0);
		// Counter read held open while it keeps counting
		fork
			issue_random(10);
			bus_hold(1'b0, 32'h100 + 32'(4 * abacus_isa_pkg::CLS_ADD), '0);
		join
		end_test("enable registers and held requests");

		$display("Summary: %0d tests, %0d passed, %0d failed", test_num - 1, pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
